// File: vector_lane.f
+incdir+rtl
+incdir+sim
rtl/lane_pkg.sv
rtl/vreg_file.sv
rtl/elem_extract.sv
rtl/lane_alu.sv
rtl/lane_writeback.sv
rtl/vector_lane.sv
sim/tb_vector_lane.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_vector_lane
RTL_TOP    ?= vector_lane
FILELIST   ?= vector_lane.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/lane_ref_model.svh
`ifndef LANE_REF_MODEL_SVH
`define LANE_REF_MODEL_SVH

//////////////////////////////
// Model state
//////////////////////////////

logic [31:0] ref_vrf [`LANE_VRF_DEPTH];
logic        ref_vmrf [`LANE_VMRF_DEPTH];

// Read stage holds the last word per port
logic [31:0] rd_word [`LANE_R_PORTS];
logic [1:0]  rd_idx [`LANE_R_PORTS];
logic [31:0] elem_e1 [`LANE_R_PORTS];

// Issued ops in flight where entry s is the op after edge E(s)
slot_op_t    op_q [3][`LANE_SLOTS];
logic        vbit_q [3][`LANE_SLOTS];
logic [31:0] res_e2 [`LANE_SLOTS];
logic        mask_e2 [`LANE_SLOTS];
logic [31:0] load_e2;

task automatic clear_model();
    for (int a = 0; a < `LANE_VRF_DEPTH; a++) begin
        ref_vrf[a] = '0;
    end
    for (int a = 0; a < `LANE_VMRF_DEPTH; a++) begin
        ref_vmrf[a] = 1'b0;
    end
    for (int p = 0; p < `LANE_R_PORTS; p++) begin
        rd_word[p] = '0;
        rd_idx[p]  = '0;
        elem_e1[p] = '0;
    end
    for (int s = 0; s < 3; s++) begin
        for (int j = 0; j < `LANE_SLOTS; j++) begin
            op_q[s][j]   = '0;
            vbit_q[s][j] = 1'b0;
        end
    end
    for (int j = 0; j < `LANE_SLOTS; j++) begin
        res_e2[j]  = '0;
        mask_e2[j] = 1'b0;
    end
    load_e2 = '0;
endtask

// Zero-extended element by SEW
function automatic logic [31:0] pick_element(logic [31:0] word, logic [1:0] idx, sew_e sew);
    case (sew)
        SEW_BYTE: return {24'b0, word[idx*8 +: 8]};
        SEW_HALF: return {16'b0, word[idx[0]*16 +: 16]};
        default:  return word;
    endcase
endfunction

task automatic compute_alu(input slot_op_t op, input logic [31:0] a, input logic [31:0] b,
                           output logic [31:0] res, output logic mask);
    logic [31:0] op2;
    case (op.op2_src)
        OP2_VEC:    op2 = b;
        OP2_SCALAR: op2 = op.x_data;
        OP2_IMM:    op2 = {27'b0, op.imm};
        default:    op2 = '0;
    endcase
    mask = 1'b0;
    case (op.alu_op)
        ALU_ADD:  res = a + op2;
        ALU_SUB:  res = a - op2;
        ALU_AND:  res = a & op2;
        ALU_OR:   res = a | op2;
        ALU_XOR:  res = a ^ op2;
        ALU_SEQ:  mask = (a == op2);
        ALU_SLTU: mask = (a < op2);
        default:  res = '0;
    endcase
    if (op.alu_op == ALU_SEQ || op.alu_op == ALU_SLTU) begin
        res = {31'b0, mask};
    end
endtask

// One rising edge with the inputs sampled there
task automatic advance_model();
    logic [31:0] rd_new [`LANE_R_PORTS];
    logic        vbit_new [`LANE_SLOTS];
    logic [31:0] wdata;
    // Reads see the arrays before this edge's writes
    for (int p = 0; p < `LANE_R_PORTS; p++) begin
        rd_new[p] = rd_req_i[p].ren ? ref_vrf[rd_req_i[p].addr] : rd_word[p];
    end
    for (int j = 0; j < `LANE_SLOTS; j++) begin
        vbit_new[j] = ref_vmrf[slot_op_i[j].vmrf_addr];
    end
    // E3 writes with slot 1 last so it wins a clash
    for (int j = 0; j < `LANE_SLOTS; j++) begin
        if (op_q[2][j].valid) begin
            wdata = (op_q[2][j].wdata_src == WD_LOAD) ? load_e2 : res_e2[j];
            for (int b = 0; b < 4; b++) begin
                if (op_q[2][j].bwen[b] && (!op_q[2][j].vm || vbit_q[2][j])) begin
                    ref_vrf[op_q[2][j].waddr][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            if (op_q[2][j].vmrf_wen) begin
                ref_vmrf[op_q[2][j].vmrf_addr] = mask_e2[j];
            end
        end
    end
    for (int j = 0; j < `LANE_SLOTS; j++) begin
        compute_alu(op_q[1][j], elem_e1[2*j], elem_e1[2*j+1], res_e2[j], mask_e2[j]);
    end
    load_e2 = load_data_i;
    for (int p = 0; p < `LANE_R_PORTS; p++) begin
        elem_e1[p] = pick_element(rd_word[p], rd_idx[p], sew_i);
        rd_word[p] = rd_new[p];
        rd_idx[p]  = rd_req_i[p].el_idx;
    end
    for (int j = 0; j < `LANE_SLOTS; j++) begin
        op_q[2][j]   = op_q[1][j];
        op_q[1][j]   = op_q[0][j];
        op_q[0][j]   = slot_op_i[j];
        vbit_q[2][j] = vbit_q[1][j];
        vbit_q[1][j] = vbit_q[0][j];
        vbit_q[0][j] = vbit_new[j];
    end
endtask

`endif

// File: sim/tb_vector_lane.sv
`timescale 1ns/1ps

`include "lane_defines.svh"

module tb_vector_lane;

    import lane_pkg::*;

    localparam logic [31:0] SEED = 32'hc74f455f;
    localparam int RAND_OPS        = 300;
    localparam int MASK_OPS        = 120;
    localparam int READBACK_CYCLES = `LANE_VRF_DEPTH / 2;
    localparam int FLUSH_CYCLES    = 4;
    localparam int TOTAL_CYCLES    = 3 + 2 * (READBACK_CYCLES + FLUSH_CYCLES)
                                   + 3 * (RAND_OPS + FLUSH_CYCLES) + 2 * MASK_OPS + FLUSH_CYCLES;
    localparam int WATCHDOG_NS     = TOTAL_CYCLES * 10 + 500;

    // Stimulus kinds
    localparam int MIX_OPS = 0;
    localparam int CMP_OPS = 1;
    localparam int MASK_WR = 2;

    logic                                 clk_i = 1'b0;
    logic                                 rst_i;
    sew_e                                 sew_i;
    rd_req_t  [`LANE_R_PORTS-1:0]         rd_req_i;
    slot_op_t [`LANE_SLOTS-1:0]           slot_op_i;
    logic [`LANE_DW-1:0]                  load_data_i;
    logic [`LANE_SLOTS-1:0][`LANE_DW-1:0] alu_result_o;
    logic [`LANE_SLOTS-1:0]               alu_valid_o;

    logic [`LANE_VRF_AW-1:0] recent_waddr [$];

    `include "lane_ref_model.svh"

    vector_lane u_vector_lane (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .sew_i        (sew_i),
        .rd_req_i     (rd_req_i),
        .slot_op_i    (slot_op_i),
        .load_data_i  (load_data_i),
        .alu_result_o (alu_result_o),
        .alu_valid_o  (alu_valid_o)
    );

    always #5 clk_i = ~clk_i;

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t",
                     name, actual, expected, $time);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic compare_outputs();
        for (int j = 0; j < `LANE_SLOTS; j++) begin
            check_value($sformatf("alu_valid_o[%0d]", j), 32'(alu_valid_o[j]),
                        32'(op_q[2][j].valid));
            if (op_q[2][j].valid) begin
                check_value($sformatf("alu_result_o[%0d]", j), alu_result_o[j], res_e2[j]);
            end
        end
    endtask

    // Inputs change 1 ns after the edge, so the model sees what the DUT sampled
    task automatic run_cycle();
        @(posedge clk_i);
        #1;
        if (!rst_i) begin
            clear_model();
        end else begin
            advance_model();
        end
        compare_outputs();
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic drive_idle();
        rd_req_i    = '0;
        slot_op_i   = '0;
        load_data_i = '0;
    endtask

    task automatic flush_pipeline();
        drive_idle();
        repeat (FLUSH_CYCLES) begin
            run_cycle();
        end
    endtask

    task automatic drive_random_op(input int kind);
        slot_op_t op;
        for (int j = 0; j < `LANE_SLOTS; j++) begin
            op           = '0;
            op.valid     = ($urandom_range(0, 7) != 0);
            op.alu_op    = alu_op_e'(3'($urandom_range(0, 6)));
            op.op2_src   = op2_src_e'(2'($urandom_range(0, 2)));
            op.x_data    = $urandom;
            op.imm       = 5'($urandom);
            op.wdata_src = wdata_src_e'(1'($urandom));
            // Top address bit picks the slot's half of the VRF
            op.waddr     = {1'(j), 4'($urandom)};
            op.bwen      = 4'($urandom);
            op.vm        = 1'($urandom);
            op.vmrf_addr = 3'($urandom);
            op.vmrf_wen  = 1'($urandom);
            if (kind == CMP_OPS) begin
                op.alu_op   = ($urandom_range(0, 1) == 1) ? ALU_SEQ : ALU_SLTU;
                op.vm       = 1'b0;
                op.vmrf_wen = 1'b1;
            end else if (kind == MASK_WR) begin
                op.alu_op   = alu_op_e'(3'($urandom_range(0, 4)));
                op.vm       = 1'b1;
                op.vmrf_wen = 1'b0;
            end
            slot_op_i[j] = op;
            if (op.valid && op.bwen != 4'b0) begin
                recent_waddr.push_back(op.waddr);
            end
        end
        while (recent_waddr.size() > 8) begin
            void'(recent_waddr.pop_front());
        end
        for (int p = 0; p < `LANE_R_PORTS; p++) begin
            rd_req_i[p].ren    = ($urandom_range(0, 7) != 0);
            rd_req_i[p].el_idx = 2'($urandom);
            // Often reread a fresh write address to hit varied distances
            if (recent_waddr.size() > 0 && $urandom_range(0, 1) == 1) begin
                rd_req_i[p].addr = recent_waddr[$urandom_range(0, recent_waddr.size() - 1)];
            end else begin
                rd_req_i[p].addr = 5'($urandom);
            end
        end
        // Same word on both ports so SEQ sets the mask
        if (kind == CMP_OPS && $urandom_range(0, 1) == 1) begin
            rd_req_i[1] = rd_req_i[0];
            rd_req_i[3] = rd_req_i[2];
        end
        load_data_i = $urandom;
    endtask

    // ADD with immediate 0 returns each whole word
    task automatic readback_all();
        slot_op_t op;
        for (int a = 0; a < READBACK_CYCLES; a++) begin
            drive_idle();
            for (int j = 0; j < `LANE_SLOTS; j++) begin
                op                 = '0;
                op.valid           = 1'b1;
                op.alu_op          = ALU_ADD;
                op.op2_src         = OP2_IMM;
                slot_op_i[j]       = op;
                rd_req_i[2*j].ren  = 1'b1;
                rd_req_i[2*j].addr = 5'(a + j * READBACK_CYCLES);
            end
            run_cycle();
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        void'($urandom(SEED));
        rst_i       = 1'b0;
        sew_i       = SEW_WORD;
        drive_idle();
        repeat (3) begin
            run_cycle();
        end
        rst_i = 1'b1;
        check_value("alu_valid_o", 32'(alu_valid_o), 32'h0);

        readback_all();
        flush_pipeline();

        for (int s = 0; s < 3; s++) begin
            sew_i = sew_e'(2'(s));
            repeat (RAND_OPS) begin
                drive_random_op(MIX_OPS);
                run_cycle();
            end
            flush_pipeline();
        end

        // Fill the VMRF with compares, then write under the mask
        sew_i = SEW_WORD;
        repeat (MASK_OPS) begin
            drive_random_op(CMP_OPS);
            run_cycle();
        end
        repeat (MASK_OPS) begin
            drive_random_op(MASK_WR);
            run_cycle();
        end
        flush_pipeline();

        readback_all();
        flush_pipeline();

        $display("TEST PASSED");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: rtl/vector_lane.sv
`timescale 1ns/1ps

`include "lane_defines.svh"

module vector_lane (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  lane_pkg::sew_e                            sew_i,
    input  lane_pkg::rd_req_t [`LANE_R_PORTS-1:0]     rd_req_i,
    input  lane_pkg::slot_op_t [`LANE_SLOTS-1:0]      slot_op_i,
    input  logic [`LANE_DW-1:0]                       load_data_i,
    output logic [`LANE_SLOTS-1:0][`LANE_DW-1:0]      alu_result_o,
    output logic [`LANE_SLOTS-1:0]                    alu_valid_o
);

    import lane_pkg::*;

    // VRF read side
    logic [`LANE_R_PORTS-1:0]                    vrf_ren;
    logic [`LANE_R_PORTS-1:0][`LANE_VRF_AW-1:0]  vrf_raddr;
    logic [`LANE_R_PORTS-1:0][`LANE_DW-1:0]      vrf_rdata;
    logic [`LANE_R_PORTS-1:0][`LANE_DW-1:0]      elem;

    // One write port per slot
    logic [`LANE_SLOTS-1:0][`LANE_VRF_AW-1:0]    vrf_waddr;
    logic [`LANE_SLOTS-1:0][`LANE_DW/8-1:0]      vrf_wen;
    logic [`LANE_SLOTS-1:0][`LANE_DW-1:0]        vrf_wdata;
    logic [`LANE_SLOTS-1:0][`LANE_VMRF_AW-1:0]   vmrf_raddr;
    logic [`LANE_SLOTS-1:0]                      vmrf_rdata;
    logic [`LANE_SLOTS-1:0][`LANE_VMRF_AW-1:0]   vmrf_waddr;
    logic [`LANE_SLOTS-1:0]                      vmrf_wen;
    logic [`LANE_SLOTS-1:0]                      vmrf_wdata;

    // Op and mask alignment with the extractors
    slot_op_t [`LANE_SLOTS-1:0]                  op_s0;
    slot_op_t [`LANE_SLOTS-1:0]                  op_s1;
    logic [`LANE_SLOTS-1:0]                      vmask_s1;

    // ALU stage outputs
    logic [`LANE_SLOTS-1:0]                      alu_mask;
    logic [`LANE_SLOTS-1:0]                      alu_vmask;
    wb_req_t [`LANE_SLOTS-1:0]                   alu_wb;

    //////////////////////////////
    // Register files
    //////////////////////////////

    vreg_file #(
        .DEPTH   (`LANE_VRF_DEPTH),
        .WIDTH   (`LANE_DW),
        .R_PORTS (`LANE_R_PORTS),
        .W_PORTS (`LANE_SLOTS)
    ) u_vrf (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .ren_i   (vrf_ren),
        .raddr_i (vrf_raddr),
        .waddr_i (vrf_waddr),
        .wen_i   (vrf_wen),
        .wdata_i (vrf_wdata),
        .rdata_o (vrf_rdata)
    );

    // Mask file is read every cycle through one port per slot
    vreg_file #(
        .DEPTH   (`LANE_VMRF_DEPTH),
        .WIDTH   (1),
        .R_PORTS (`LANE_SLOTS),
        .W_PORTS (`LANE_SLOTS)
    ) u_vmrf (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .ren_i   ({`LANE_SLOTS{1'b1}}),
        .raddr_i (vmrf_raddr),
        .waddr_i (vmrf_waddr),
        .wen_i   (vmrf_wen),
        .wdata_i (vmrf_wdata),
        .rdata_o (vmrf_rdata)
    );

    //////////////////////////////
    // Read ports and extractors
    //////////////////////////////

    for (genvar i = 0; i < `LANE_R_PORTS; i++) begin : g_rd
        assign vrf_ren[i]   = rd_req_i[i].ren;
        assign vrf_raddr[i] = rd_req_i[i].addr;

        elem_extract u_extract (
            .clk_i    (clk_i),
            .rst_i    (rst_i),
            .rdata_i  (vrf_rdata[i]),
            .el_idx_i (rd_req_i[i].el_idx),
            .sew_i    (sew_i),
            .elem_o   (elem[i])
        );
    end

    //////////////////////////////
    // Op pipeline
    //////////////////////////////

    // First stage samples with the VRF read, second matches the extractor output
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            op_s0    <= '0;
            op_s1    <= '0;
            vmask_s1 <= '0;
        end else begin
            op_s0    <= slot_op_i;
            op_s1    <= op_s0;
            vmask_s1 <= vmrf_rdata;
        end
    end

    //////////////////////////////
    // Slots
    //////////////////////////////

    for (genvar j = 0; j < `LANE_SLOTS; j++) begin : g_slot
        assign vmrf_raddr[j] = slot_op_i[j].vmrf_addr;

        lane_alu u_alu (
            .clk_i    (clk_i),
            .rst_i    (rst_i),
            .op_i     (op_s1[j]),
            .vmask_i  (vmask_s1[j]),
            .elem_a_i (elem[2*j]),
            .elem_b_i (elem[2*j+1]),
            .result_o (alu_result_o[j]),
            .mask_o   (alu_mask[j]),
            .valid_o  (alu_valid_o[j]),
            .wb_o     (alu_wb[j]),
            .vmask_o  (alu_vmask[j])
        );

        lane_writeback u_wb (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .wb_i         (alu_wb[j]),
            .result_i     (alu_result_o[j]),
            .mask_i       (alu_mask[j]),
            .valid_i      (alu_valid_o[j]),
            .vmask_i      (alu_vmask[j]),
            .load_data_i  (load_data_i),
            .vrf_waddr_o  (vrf_waddr[j]),
            .vrf_wen_o    (vrf_wen[j]),
            .vrf_wdata_o  (vrf_wdata[j]),
            .vmrf_waddr_o (vmrf_waddr[j]),
            .vmrf_wen_o   (vmrf_wen[j]),
            .vmrf_wdata_o (vmrf_wdata[j])
        );
    end

endmodule

// File: rtl/lane_writeback.sv
`timescale 1ns/1ps

`include "lane_defines.svh"

module lane_writeback (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  lane_pkg::wb_req_t         wb_i,
    input  logic [`LANE_DW-1:0]       result_i,
    input  logic                      mask_i,
    input  logic                      valid_i,
    input  logic                      vmask_i,
    input  logic [`LANE_DW-1:0]       load_data_i,
    output logic [`LANE_VRF_AW-1:0]   vrf_waddr_o,
    output logic [`LANE_DW/8-1:0]     vrf_wen_o,
    output logic [`LANE_DW-1:0]       vrf_wdata_o,
    output logic [`LANE_VMRF_AW-1:0]  vmrf_waddr_o,
    output logic                      vmrf_wen_o,
    output logic                      vmrf_wdata_o
);

    import lane_pkg::*;

    logic [`LANE_DW-1:0] load_q;
    logic                wr_ok;

    //////////////////////////////
    // Load data capture
    //////////////////////////////

    // Sampled on the same edge as the ALU result
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            load_q <= '0;
        end else begin
            load_q <= load_data_i;
        end
    end

    //////////////////////////////
    // VRF write port
    //////////////////////////////

    // Masked ops only write where the VMRF bit is set
    assign wr_ok = valid_i & (~wb_i.vm | vmask_i);

    assign vrf_waddr_o = wb_i.waddr;
    assign vrf_wen_o   = wb_i.bwen & {(`LANE_DW/8){wr_ok}};

    always_comb begin
        if (wb_i.wdata_src == WD_LOAD) begin
            vrf_wdata_o = load_q;
        end else begin
            vrf_wdata_o = result_i;
        end
    end

    //////////////////////////////
    // VMRF write port
    //////////////////////////////

    // Compare outcome goes back regardless of vm
    assign vmrf_waddr_o = wb_i.vmrf_addr;
    assign vmrf_wen_o   = wb_i.vmrf_wen & valid_i;
    assign vmrf_wdata_o = mask_i;

endmodule

// File: rtl/lane_alu.sv
`timescale 1ns/1ps

module lane_alu (
    input  logic              clk_i,
    input  logic              rst_i,
    input  lane_pkg::slot_op_t op_i,
    input  logic              vmask_i,
    input  logic [31:0]       elem_a_i,
    input  logic [31:0]       elem_b_i,
    output logic [31:0]       result_o,
    output logic              mask_o,
    output logic              valid_o,
    output lane_pkg::wb_req_t wb_o,
    output logic              vmask_o
);

    import lane_pkg::*;

    logic [31:0] op2;
    logic [31:0] result_d;
    logic        mask_d;

    //////////////////////////////
    // Operand 2 select
    //////////////////////////////

    always_comb begin
        case (op_i.op2_src)
            OP2_VEC:    op2 = elem_b_i;
            OP2_SCALAR: op2 = op_i.x_data;
            OP2_IMM:    op2 = {27'b0, op_i.imm};
            default:    op2 = '0;
        endcase
    end

    //////////////////////////////
    // Datapath
    //////////////////////////////

    always_comb begin
        mask_d = 1'b0;
        case (op_i.alu_op)
            ALU_ADD: result_d = elem_a_i + op2;
            ALU_SUB: result_d = elem_a_i - op2;
            ALU_AND: result_d = elem_a_i & op2;
            ALU_OR:  result_d = elem_a_i | op2;
            ALU_XOR: result_d = elem_a_i ^ op2;
            ALU_SEQ: begin
                mask_d   = (elem_a_i == op2);
                result_d = {31'b0, mask_d};
            end
            ALU_SLTU: begin
                mask_d   = (elem_a_i < op2);
                result_d = {31'b0, mask_d};
            end
            default: result_d = '0;
        endcase
    end

    // Result register with the write fields riding along
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            result_o <= '0;
            mask_o   <= 1'b0;
            valid_o  <= 1'b0;
            wb_o     <= '0;
            vmask_o  <= 1'b0;
        end else begin
            result_o <= result_d;
            mask_o   <= mask_d;
            valid_o  <= op_i.valid;
            wb_o     <= '{wdata_src: op_i.wdata_src, waddr: op_i.waddr, bwen: op_i.bwen,
                          vm: op_i.vm, vmrf_addr: op_i.vmrf_addr, vmrf_wen: op_i.vmrf_wen};
            vmask_o  <= vmask_i;
        end
    end

endmodule

// File: rtl/elem_extract.sv
`timescale 1ns/1ps

module elem_extract (
    input  logic                clk_i,
    input  logic                rst_i,
    input  lane_pkg::vrf_word_u rdata_i,
    input  logic [1:0]          el_idx_i,
    input  lane_pkg::sew_e      sew_i,
    output logic [31:0]         elem_o
);

    import lane_pkg::*;

    logic [1:0]  idx_q;
    logic [31:0] elem_d;

    //////////////////////////////
    // Index alignment
    //////////////////////////////

    // Index is sampled with the read address, so it lines up with the VRF data
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            idx_q <= '0;
        end else begin
            idx_q <= el_idx_i;
        end
    end

    //////////////////////////////
    // Element select
    //////////////////////////////

    always_comb begin
        case (sew_i)
            SEW_BYTE: elem_d = {24'b0, rdata_i.b[idx_q]};
            // Halfword index uses only the low bit
            SEW_HALF: elem_d = {16'b0, rdata_i.h[idx_q[0]]};
            default:  elem_d = rdata_i.w;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            elem_o <= '0;
        end else begin
            elem_o <= elem_d;
        end
    end

endmodule

// File: rtl/vreg_file.sv
`timescale 1ns/1ps

module vreg_file #(
    parameter int DEPTH   = 32,
    parameter int WIDTH   = 32,
    parameter int R_PORTS = 4,
    parameter int W_PORTS = 2,
    localparam int AW     = $clog2(DEPTH),
    localparam int WEN_W  = (WIDTH + 7) / 8
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [R_PORTS-1:0]                  ren_i,
    input  logic [R_PORTS-1:0][AW-1:0]          raddr_i,
    input  logic [W_PORTS-1:0][AW-1:0]          waddr_i,
    input  logic [W_PORTS-1:0][WEN_W-1:0]       wen_i,
    input  logic [W_PORTS-1:0][WIDTH-1:0]       wdata_i,
    output logic [R_PORTS-1:0][WIDTH-1:0]       rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    //////////////////////////////
    // Array and read registers
    //////////////////////////////

    // Reads take the old contents when a write hits the same edge
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int d = 0; d < DEPTH; d++) begin
                mem[d] <= '0;
            end
            for (int r = 0; r < R_PORTS; r++) begin
                rdata_o[r] <= '0;
            end
        end else begin
            for (int r = 0; r < R_PORTS; r++) begin
                // Output holds while the port is idle
                if (ren_i[r]) begin
                    rdata_o[r] <= mem[raddr_i[r]];
                end
            end
            // Later ports overwrite earlier ones on an address clash
            for (int w = 0; w < W_PORTS; w++) begin
                for (int k = 0; k < WIDTH; k++) begin
                    if (wen_i[w][k / 8]) begin
                        mem[waddr_i[w]][k] <= wdata_i[w][k];
                    end
                end
            end
        end
    end

endmodule

// File: rtl/lane_pkg.sv
`include "lane_defines.svh"

package lane_pkg;

    // Element width
    typedef enum logic [1:0] {
        SEW_BYTE = 2'd0,
        SEW_HALF = 2'd1,
        SEW_WORD = 2'd2
    } sew_e;

    // Compares set the mask bit, the rest are plain data ops
    typedef enum logic [`LANE_OP_W-1:0] {
        ALU_ADD  = `LANE_OP_ADD,
        ALU_SUB  = `LANE_OP_SUB,
        ALU_AND  = `LANE_OP_AND,
        ALU_OR   = `LANE_OP_OR,
        ALU_XOR  = `LANE_OP_XOR,
        ALU_SEQ  = `LANE_OP_SEQ,
        ALU_SLTU = `LANE_OP_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        OP2_VEC    = 2'd0,
        OP2_SCALAR = 2'd1,
        OP2_IMM    = 2'd2
    } op2_src_e;

    typedef enum logic {
        WD_ALU  = 1'b0,
        WD_LOAD = 1'b1
    } wdata_src_e;

    // One VRF word seen whole, as bytes or as halfwords
    typedef union packed {
        logic [`LANE_DW-1:0]           w;
        logic [`LANE_DW/8-1:0][7:0]    b;
        logic [`LANE_DW/16-1:0][15:0]  h;
    } vrf_word_u;

    typedef struct packed {
        logic                    ren;
        logic [`LANE_VRF_AW-1:0] addr;
        logic [1:0]              el_idx;
    } rd_req_t;

    typedef struct packed {
        logic                     valid;
        alu_op_e                  alu_op;
        op2_src_e                 op2_src;
        logic [`LANE_DW-1:0]      x_data;
        logic [4:0]               imm;
        wdata_src_e               wdata_src;
        logic [`LANE_VRF_AW-1:0]  waddr;
        logic [`LANE_DW/8-1:0]    bwen;
        logic                     vm;
        logic [`LANE_VMRF_AW-1:0] vmrf_addr;
        logic                     vmrf_wen;
    } slot_op_t;

    // Write fields carried past the ALU
    typedef struct packed {
        wdata_src_e               wdata_src;
        logic [`LANE_VRF_AW-1:0]  waddr;
        logic [`LANE_DW/8-1:0]    bwen;
        logic                     vm;
        logic [`LANE_VMRF_AW-1:0] vmrf_addr;
        logic                     vmrf_wen;
    } wb_req_t;

endpackage

// File: rtl/lane_defines.svh
`ifndef LANE_DEFINES_SVH
`define LANE_DEFINES_SVH

//////////////////////////////
// Port counts
//////////////////////////////

// Slot j reads through ports 2j and 2j+1
`define LANE_R_PORTS 4
`define LANE_SLOTS 2

//////////////////////////////
// Register file geometry
//////////////////////////////

`define LANE_VRF_DEPTH 32
`define LANE_VRF_AW 5
`define LANE_VMRF_DEPTH 8
`define LANE_VMRF_AW 3
`define LANE_DW 32

//////////////////////////////
// ALU op encoding
//////////////////////////////

`define LANE_OP_W 3
`define LANE_OP_ADD 3'd0
`define LANE_OP_SUB 3'd1
`define LANE_OP_AND 3'd2
`define LANE_OP_OR 3'd3
`define LANE_OP_XOR 3'd4
`define LANE_OP_SEQ 3'd5
`define LANE_OP_SLTU 3'd6

`endif
